/* fsb_pkg.sv */
/*
 * shared definitions for the four-node front-side-bus fabric
 * packet word with its data and switch-command views, response word,
 * opcodes and sizing constants; modules import this package
 */
`default_nettype none

package fsb_pkg;

   // fabric sizing
   localparam int NUM_NODES     = 4;
   localparam int ID_WIDTH      = 2;
   localparam int PKT_WIDTH     = 32;
   localparam int PAYLOAD_WIDTH = 29;
   localparam int SUM_WIDTH     = 30;

   // switch opcodes
   // any other value is ignored by the gateway
   typedef enum logic [3:0]
   {
      ENABLE_CMD        = 4'd1,
      DISABLE_CMD       = 4'd2,
      RESET_ENABLE_CMD  = 4'd3,
      RESET_DISABLE_CMD = 4'd4
   } fsb_opcode_e;

   // data view with cmd at 0
   typedef struct packed
   {
      logic [ID_WIDTH-1:0]      destid;
      logic                     cmd;
      logic [PAYLOAD_WIDTH-1:0] payload;
   } fsb_pkt_data_s;

   // switch command view with cmd at 1
   typedef struct packed
   {
      logic [ID_WIDTH-1:0] destid;
      logic                cmd;
      fsb_opcode_e         opcode;
      logic [24:0]         unused;
   } fsb_pkt_cmd_s;

   // destid and cmd line up in both views
   typedef union packed
   {
      fsb_pkt_data_s data_view;
      fsb_pkt_cmd_s  cmd_view;
   } fsb_pkt_u;

   // node response tagged with the source node id
   typedef struct packed
   {
      logic [ID_WIDTH-1:0]  srcid;
      logic [SUM_WIDTH-1:0] sum;
   } fsb_resp_s;

endpackage

`default_nettype wire

/* fsb_input_stage.sv */
/*
 * one-entry buffer between the switch and the broadcast lanes
 * a packet is held and offered to every gateway until all of them
 * have taken it in the same cycle
 */
`timescale 1ns/100ps
`default_nettype none

module fsb_input_stage
(
   input  logic                            clk_i,
   input  logic                            reset_i,

   // from the switch
   input  logic                            in_v_i,
   input  fsb_pkg::fsb_pkt_u               in_data_i,
   output logic                            in_ready_o,

   // broadcast to the lanes
   output logic                            pkt_v_o,
   output fsb_pkg::fsb_pkt_u               pkt_o,
   input  logic [fsb_pkg::NUM_NODES-1:0]   lane_ready_i
);

   import fsb_pkg::*;

   logic      pkt_v_r;
   fsb_pkt_u  pkt_r;
   logic      consume;

   // every lane must take the packet in the same cycle
   assign consume = pkt_v_r & (&lane_ready_i);

   // free when empty or draining this cycle
   assign in_ready_o = ~pkt_v_r | consume;

   assign pkt_v_o = pkt_v_r;
   assign pkt_o   = pkt_r;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         pkt_v_r <= 1'b0;
      else if (in_ready_o)
         pkt_v_r <= in_v_i;
   end

   // packet word loads on an accepted transfer
   always_ff @(posedge clk_i)
   begin
      if (in_ready_o & in_v_i)
         pkt_r <= in_data_i;
   end

   // a waiting packet stays put until every lane has it
   a_pkt_stable : assert property (@(posedge clk_i) disable iff (reset_i)
      pkt_v_r && !consume |=> pkt_v_r && $stable(pkt_r))
      else $error("input stage packet changed while waiting");

endmodule

`default_nettype wire

/* fsb_gateway.sv */
/*
 * per-node gateway in front of one node
 * runs switch commands addressed to its id, forwards data to the node
 * while it is enabled, and sinks everything else
 * ready_o looks at v_i in the same cycle
 */
`timescale 1ns/100ps
`default_nettype none

module fsb_gateway
#(
   parameter int unsigned NODE_ID = 0
)
(
   input  logic               clk_i,
   input  logic               reset_i,

   // from/to the input stage
   input  logic               v_i,
   input  fsb_pkg::fsb_pkt_u  data_i,
   output logic               ready_o,

   // to/from the node
   output logic               v_o,
   input  logic               ready_i,
   output logic               node_en_o,
   output logic               node_reset_o
);

   import fsb_pkg::*;

   logic node_en_r;
   logic node_en_n;
   logic node_reset_r;
   logic node_reset_n;
   logic id_match;
   logic for_this_node;
   logic for_switch;

   assign node_en_o    = node_en_r;
   assign node_reset_o = node_reset_r;

   // destid and cmd decode the same in either view
   assign id_match      = (data_i.data_view.destid == ID_WIDTH'(NODE_ID));
   assign for_this_node = v_i & id_match;
   assign for_switch    = for_this_node & data_i.data_view.cmd;

   // only enabled, id-matching data reaches the node
   assign v_o = node_en_r & for_this_node & ~for_switch;

   // sink when node asleep, node ready, command, or someone else's packet
   assign ready_o = v_i
                    & (~node_en_r
                       | ready_i
                       | for_switch
                       | ~for_this_node);

   // commands land at the edge that consumes them
   // a repeated offer just rewrites the same value
   always_comb
   begin
      node_en_n    = node_en_r;
      node_reset_n = node_reset_r;
      if (for_switch)
      begin
         case (data_i.cmd_view.opcode)
            ENABLE_CMD:        node_en_n    = 1'b1;
            DISABLE_CMD:       node_en_n    = 1'b0;
            RESET_ENABLE_CMD:  node_reset_n = 1'b1;
            RESET_DISABLE_CMD: node_reset_n = 1'b0;
            default:           ;
         endcase
      end
   end

   // node comes up disabled and held in reset
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         node_en_r    <= 1'b0;
         node_reset_r <= 1'b1;
      end
      else
      begin
         node_en_r    <= node_en_n;
         node_reset_r <= node_reset_n;
      end
   end

   a_fwd_enabled : assert property (@(posedge clk_i) disable iff (reset_i)
      v_o |-> node_en_r)
      else $error("gateway %0d forwarded while disabled", NODE_ID);

   a_fwd_data_only : assert property (@(posedge clk_i) disable iff (reset_i)
      v_o |-> !data_i.data_view.cmd)
      else $error("gateway %0d forwarded a switch command", NODE_ID);

endmodule

`default_nettype wire

/* fsb_node.sv */
/*
 * per-node payload accumulator
 * each accepted payload is added to a 30-bit running sum and one
 * response with the node id and the new sum is held until granted
 */
`timescale 1ns/100ps
`default_nettype none

module fsb_node
#(
   parameter int unsigned NODE_ID = 0
)
(
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic               node_reset_i,

   // data from the gateway
   input  logic               v_i,
   input  fsb_pkg::fsb_pkt_u  data_i,
   output logic               ready_o,

   // response to the merge
   output logic               resp_v_o,
   output fsb_pkg::fsb_resp_s resp_o,
   input  logic               resp_ready_i
);

   import fsb_pkg::*;

   logic                 resp_v_r;
   logic [SUM_WIDTH-1:0] sum_r;
   logic                 accept;

   // packets are sunk in node reset and otherwise taken one response at a time
   assign ready_o = node_reset_i | ~resp_v_r;
   assign accept  = v_i & ready_o & ~node_reset_i;

   assign resp_v_o     = resp_v_r;
   assign resp_o.srcid = ID_WIDTH'(NODE_ID);
   assign resp_o.sum   = sum_r;

   always_ff @(posedge clk_i)
   begin
      if (reset_i | node_reset_i)
      begin
         sum_r    <= '0;
         resp_v_r <= 1'b0;
      end
      else if (accept)
      begin
         // wraps modulo 2^30
         sum_r    <= sum_r + SUM_WIDTH'(data_i.data_view.payload);
         resp_v_r <= 1'b1;
      end
      else if (resp_v_r & resp_ready_i)
         resp_v_r <= 1'b0;
   end

   a_no_accept_pending : assert property (@(posedge clk_i) disable iff (reset_i)
      resp_v_r && !node_reset_i |-> !accept)
      else $error("node %0d took data with a response pending", NODE_ID);

endmodule

`default_nettype wire

/* fsb_output_merge.sv */
/*
 * round-robin merge of the node responses onto the output port
 * grant is combinational and doubles as each lane's ready
 * the search starts after the last granted lane and the pointer
 * moves on each output transfer
 */
`timescale 1ns/100ps
`default_nettype none

module fsb_output_merge
(
   input  logic                                       clk_i,
   input  logic                                       reset_i,

   input  logic [fsb_pkg::NUM_NODES-1:0]              resp_v_i,
   input  fsb_pkg::fsb_resp_s [fsb_pkg::NUM_NODES-1:0] resp_i,
   output logic [fsb_pkg::NUM_NODES-1:0]              grant_o,

   output logic                                       out_v_o,
   output fsb_pkg::fsb_resp_s                         out_data_o,
   input  logic                                       out_ready_i
);

   import fsb_pkg::*;

   logic [ID_WIDTH-1:0] last_r;
   logic [ID_WIDTH-1:0] sel;
   logic                found;

   // first pending lane after last_r with wraparound
   always_comb
   begin
      logic [ID_WIDTH-1:0] idx;
      sel   = last_r;
      found = 1'b0;
      for (int i = 1; i <= NUM_NODES; i++)
      begin
         idx = last_r + ID_WIDTH'(i);
         if (!found && resp_v_i[idx])
         begin
            found = 1'b1;
            sel   = idx;
         end
      end
   end

   assign out_v_o    = |resp_v_i;
   assign out_data_o = resp_i[sel];
   assign grant_o    = (found & out_ready_i) ? (NUM_NODES'(1) << sel) : '0;

   // start so that lane 0 wins first
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         last_r <= ID_WIDTH'(NUM_NODES - 1);
      else if (out_v_o & out_ready_i)
         last_r <= sel;
   end

   a_grant_legal : assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(grant_o) && ((grant_o & ~resp_v_i) == '0))
      else $error("merge grant %b illegal for valid %b", grant_o, resp_v_i);

endmodule

`default_nettype wire

/* fsb_subsystem.sv */
/*
 * top of the four-node fabric
 * input stage broadcasts each packet to four gateway/node lanes,
 * the output merge drains their responses onto one port
 */
`timescale 1ns/100ps
`default_nettype none

module fsb_subsystem
(
   input  logic               clk_i,
   input  logic               reset_i,

   input  logic               in_v_i,
   input  fsb_pkg::fsb_pkt_u  in_data_i,
   output logic               in_ready_o,

   output logic               out_v_o,
   output fsb_pkg::fsb_resp_s out_data_o,
   input  logic               out_ready_i
);

   import fsb_pkg::*;

   logic                         pkt_v;
   fsb_pkt_u                     pkt;
   logic [NUM_NODES-1:0]         lane_ready;
   logic [NUM_NODES-1:0]         node_v;
   logic [NUM_NODES-1:0]         node_ready;
   logic [NUM_NODES-1:0]         node_en;
   logic [NUM_NODES-1:0]         node_reset;
   logic [NUM_NODES-1:0]         resp_v;
   logic [NUM_NODES-1:0]         grant;
   fsb_resp_s [NUM_NODES-1:0]    resp;

   fsb_input_stage input_stage_i
   (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .in_v_i       (in_v_i),
      .in_data_i    (in_data_i),
      .in_ready_o   (in_ready_o),
      .pkt_v_o      (pkt_v),
      .pkt_o        (pkt),
      .lane_ready_i (lane_ready)
   );

   for (genvar g = 0; g < NUM_NODES; g++)
   begin : lane
      fsb_gateway #(.NODE_ID(g)) gateway_i
      (
         .clk_i        (clk_i),
         .reset_i      (reset_i),
         .v_i          (pkt_v),
         .data_i       (pkt),
         .ready_o      (lane_ready[g]),
         .v_o          (node_v[g]),
         .ready_i      (node_ready[g]),
         .node_en_o    (node_en[g]),
         .node_reset_o (node_reset[g])
      );

      fsb_node #(.NODE_ID(g)) node_i
      (
         .clk_i        (clk_i),
         .reset_i      (reset_i),
         .node_reset_i (node_reset[g]),
         .v_i          (node_v[g]),
         .data_i       (pkt),
         .ready_o      (node_ready[g]),
         .resp_v_o     (resp_v[g]),
         .resp_o       (resp[g]),
         .resp_ready_i (grant[g])
      );

      // a fresh response only comes from a lane that was enabled
      a_resp_from_enabled : assert property (@(posedge clk_i) disable iff (reset_i)
         $rose(resp_v[g]) |-> $past(node_en[g]))
         else $error("lane %0d responded while disabled", g);
   end

   fsb_output_merge output_merge_i
   (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .resp_v_i    (resp_v),
      .resp_i      (resp),
      .grant_o     (grant),
      .out_v_o     (out_v_o),
      .out_data_o  (out_data_o),
      .out_ready_i (out_ready_i)
   );

endmodule

`default_nettype wire

/* fsb_subsystem_tb.sv */
/*
 * testbench for the four-node fabric
 * drives packets on the falling edge, models every node's enable, reset
 * and sum, and checks each output transfer against per-node queues
 */
`timescale 1ns/100ps
`default_nettype none

module fsb_subsystem_tb;

   import fsb_pkg::*;

   localparam int CLK_PERIOD     = 40;
   localparam int RESET_CYCLES   = 10;
   localparam int SEED           = 35;
   localparam int DROP_PER_NODE  = 2;
   localparam int DATA_PER_NODE  = 3;
   localparam int RANDOM_PKTS    = 60;
   // reset-drop, enable+data, node reset, disable, random
   localparam int TOTAL_PKTS     = DROP_PER_NODE * NUM_NODES
                                   + (2 + DATA_PER_NODE) * NUM_NODES
                                   + 3 + 8 + RANDOM_PKTS;
   localparam int TIMEOUT_CYCLES = 40 * TOTAL_PKTS;

   logic               clk_i;
   logic               reset_i;
   logic               in_v_i;
   fsb_pkt_u           in_data_i;
   logic               in_ready_o;
   logic               out_v_o;
   fsb_resp_s          out_data_o;
   logic               out_ready_i;

   int                 seed;
   int                 ready_seed;
   int                 cycle_count;
   string              test_name;

   // reference model with one entry per node
   logic                 model_en  [NUM_NODES];
   logic                 model_rst [NUM_NODES];
   logic [SUM_WIDTH-1:0] model_sum [NUM_NODES];
   fsb_resp_s            exp_q     [NUM_NODES][$];

   fsb_subsystem dut_i
   (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .in_v_i      (in_v_i),
      .in_data_i   (in_data_i),
      .in_ready_o  (in_ready_o),
      .out_v_o     (out_v_o),
      .out_data_o  (out_data_o),
      .out_ready_i (out_ready_i)
   );

   always #(CLK_PERIOD/2) clk_i = ~clk_i;

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "check failed");
   endtask

   // node behaviour applied in acceptance order
   task automatic apply_to_model(input fsb_pkt_u p);
      int        id;
      longint    total;
      fsb_resp_s r;
      id = int'(p.data_view.destid);
      if (p.data_view.cmd)
      begin
         case (p.cmd_view.opcode)
            ENABLE_CMD:        model_en[id] = 1'b1;
            DISABLE_CMD:       model_en[id] = 1'b0;
            RESET_ENABLE_CMD:
            begin
               model_rst[id] = 1'b1;
               model_sum[id] = '0;
            end
            RESET_DISABLE_CMD: model_rst[id] = 1'b0;
            default:           ;
         endcase
      end
      else if (model_en[id] && !model_rst[id])
      begin
         // running sum kept modulo 2^30
         total         = longint'(model_sum[id]) + longint'(p.data_view.payload);
         model_sum[id] = SUM_WIDTH'(total % (longint'(1) << SUM_WIDTH));
         r.srcid       = p.data_view.destid;
         r.sum         = model_sum[id];
         exp_q[id].push_back(r);
      end
   endtask

   // starts on a falling edge and returns on the falling edge after the transfer
   task automatic send_pkt(input fsb_pkt_u p);
      bit done;
      done      = 1'b0;
      in_v_i    = 1'b1;
      in_data_i = p;
      while (!done)
      begin
         // a quarter period in everything has settled before the rising edge
         #(CLK_PERIOD/4);
         if (in_ready_o)
         begin
            apply_to_model(p);
            done = 1'b1;
         end
         @(negedge clk_i);
      end
      in_v_i = 1'b0;
   endtask

   task automatic send_data(input int id, input logic [PAYLOAD_WIDTH-1:0] payload);
      fsb_pkt_u p;
      p.data_view.destid  = ID_WIDTH'(id);
      p.data_view.cmd     = 1'b0;
      p.data_view.payload = payload;
      send_pkt(p);
   endtask

   task automatic send_cmd(input int id, input logic [3:0] op);
      fsb_pkt_u p;
      p                  = '0;
      p.cmd_view.destid  = ID_WIDTH'(id);
      p.cmd_view.cmd     = 1'b1;
      p.cmd_view.opcode  = fsb_opcode_e'(op);
      send_pkt(p);
   endtask

   function automatic logic [PAYLOAD_WIDTH-1:0] rand_payload();
      return PAYLOAD_WIDTH'($random(seed));
   endfunction

   function automatic bit all_drained();
      bit empty;
      empty = 1'b1;
      for (int n = 0; n < NUM_NODES; n++)
         if (exp_q[n].size() != 0)
            empty = 1'b0;
      return empty;
   endfunction

   task automatic wait_drain();
      while (!all_drained())
         @(negedge clk_i);
   endtask

   task automatic check_response(input fsb_resp_s got);
      int        id;
      fsb_resp_s exp;
      id = int'(got.srcid);
      assert (exp_q[id].size() > 0)
      else stop_with_failure($sformatf("unexpected response from node %0d during %s",
                                       id, test_name));
      exp = exp_q[id].pop_front();
      assert (got == exp)
      else stop_with_failure($sformatf("Fail %s: expected %h actual %h",
                                       test_name, exp, got));
   endtask

   // output monitor samples a quarter period after the falling edge
   always @(negedge clk_i)
   begin
      #(CLK_PERIOD/4);
      if (!reset_i && out_v_o && out_ready_i)
         check_response(out_data_o);
   end

   // back-pressure is low about a third of the time
   always @(negedge clk_i)
      out_ready_i = (($random(ready_seed) % 3) != 0);

   always @(posedge clk_i)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("run hung: not finished after %0d cycles", cycle_count);
         $display("STATUS: FAIL");
         $fatal(1, "timeout");
      end
   end

   initial
   begin
      int                       id;
      logic [PAYLOAD_WIDTH-1:0] big;
      clk_i       = 1'b0;
      reset_i     = 1'b1;
      in_v_i      = 1'b0;
      in_data_i   = '0;
      out_ready_i = 1'b0;
      seed        = SEED;
      ready_seed  = SEED;
      cycle_count = 0;
      test_name   = "reset";
      // nodes come up disabled and held in reset
      for (int n = 0; n < NUM_NODES; n++)
      begin
         model_en[n]  = 1'b0;
         model_rst[n] = 1'b1;
         model_sum[n] = '0;
      end
      repeat (RESET_CYCLES) @(negedge clk_i);
      reset_i = 1'b0;

      // disabled nodes sink everything
      test_name = "reset_drop";
      for (int k = 0; k < DROP_PER_NODE; k++)
         for (int n = 0; n < NUM_NODES; n++)
            send_data(n, rand_payload());

      // enable and release then build sums that wrap
      test_name = "enable_sum";
      for (int n = 0; n < NUM_NODES; n++)
      begin
         send_cmd(n, ENABLE_CMD);
         send_cmd(n, RESET_DISABLE_CMD);
      end
      for (int k = 0; k < DATA_PER_NODE; k++)
         for (int n = 0; n < NUM_NODES; n++)
         begin
            // top two payload bits set so three payloads always pass 2^30
            big = rand_payload() | (PAYLOAD_WIDTH'(3) << (PAYLOAD_WIDTH - 2));
            send_data(n, big);
         end

      // node reset drops a pending response so the queues drain first
      test_name = "node_reset";
      wait_drain();
      send_cmd(1, RESET_ENABLE_CMD);
      send_cmd(1, RESET_DISABLE_CMD);
      send_data(1, rand_payload());

      // disabled node 2 keeps its sum across other traffic
      test_name = "disable";
      send_cmd(2, DISABLE_CMD);
      send_data(2, rand_payload());
      send_data(2, rand_payload());
      send_data(0, rand_payload());
      send_data(3, rand_payload());
      send_cmd(3, 4'd0);
      send_cmd(2, ENABLE_CMD);
      send_data(2, rand_payload());

      test_name = "random_traffic";
      for (int k = 0; k < RANDOM_PKTS; k++)
      begin
         id = $unsigned($random(seed)) % NUM_NODES;
         send_data(id, rand_payload());
      end

      wait_drain();
      repeat (4) @(negedge clk_i);
      if (out_v_o)
         stop_with_failure("a response was left on the output after all queues drained");
      else
      begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* fsb_subsystem.f */
fsb_pkg.sv
fsb_input_stage.sv
fsb_gateway.sv
fsb_node.sv
fsb_output_merge.sv
fsb_subsystem.sv
fsb_subsystem_tb.sv

/* Makefile */
# Verilator simulation of the four-node fabric

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := fsb_subsystem_tb
FILELIST  := fsb_subsystem.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

# a $fatal in the run gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
